// ==== source/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

  // Instruction cycle, one instruction at a time
  typedef enum logic [2:0] {
    FETCH     = 3'd0,
    DECODE    = 3'd1,
    EXEC      = 3'd2,
    MEM       = 3'd3,
    WRITEBACK = 3'd4,
    HALT      = 3'd5
  } state_t;

  // Primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ORI     = 6'h0D,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_t;

  // Function field of SPECIAL instructions, instr[5:0]
  typedef enum logic [5:0] {
    FUNC_JR   = 6'h08,
    FUNC_ADDU = 6'h21,
    FUNC_SUBU = 6'h23,
    FUNC_AND  = 6'h24,
    FUNC_OR   = 6'h25,
    FUNC_XOR  = 6'h26,
    FUNC_SLT  = 6'h2A,
    FUNC_SLTU = 6'h2B
  } func_t;

  // Register file write destination
  typedef enum logic [1:0] {
    RD    = 2'd0,
    RT    = 2'd1,
    GPR31 = 2'd2
  } wb_sel_t;

  // First fetch address after reset, in the boot ROM segment
  localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;

  // Reaching this pc stops the core
  localparam logic [31:0] HALT_ADDRESS = 32'h0000_0000;

  // Bytes per bus word, also the byteenable width
  localparam int WORD_BYTES = 4;

endpackage

`default_nettype wire

// ==== source/mips_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_fsm
  import mips_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   stall_i,
  input  logic   halt_i,
  input  logic   mem_access_i,
  output state_t state_o
);

  state_t state_d;

  always_comb begin
    state_d = state_o;
    case (state_o)
      FETCH: begin
        if (halt_i) begin
          state_d = HALT;
        end else if (!stall_i) begin
          state_d = DECODE;
        end
      end
      DECODE:    state_d = EXEC;
      // Only loads and stores need a second bus transfer
      EXEC:      state_d = mem_access_i ? MEM : WRITEBACK;
      MEM: begin
        if (!stall_i) begin
          state_d = WRITEBACK;
        end
      end
      WRITEBACK: state_d = FETCH;
      default:   state_d = HALT;
    endcase
  end

  // Reset parks in WRITEBACK so the bus stays idle until the first fetch
  always_ff @(posedge clk) begin
    if (reset) begin
      state_o <= WRITEBACK;
    end else begin
      state_o <= state_d;
    end
  end

  // A halted core keeps its pc on the halt address
  a_halt_parked : assert property (
    @(posedge clk) disable iff (reset) state_o == HALT |-> halt_i
  ) else $error("HALT state with the pc off the halt address");

endmodule

`default_nettype wire

// ==== source/mips_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_control
  import mips_pkg::*;
(
  input  state_t  state_i,
  input  logic    waitrequest_i,
  input  opcode_t opcode_i,
  input  func_t   funct_i,
  output logic    mem_access_o,
  output logic    pc_write_en_o,
  output logic    ir_write_en_o,
  output logic    regfile_write_en_o,
  output wb_sel_t wb_sel_o,
  output logic    read_o,
  output logic    write_o,
  output logic    ram_addr_sel_o,
  output logic    alu_src_imm_o
);

  logic is_load;
  logic is_store;
  logic writes_reg;
  logic fetch_done;

  assign is_load  = opcode_i == OP_LW;
  assign is_store = opcode_i == OP_SW;

  // Instructions that write their result in WRITEBACK
  always_comb begin
    writes_reg = 1'b0;
    case (opcode_i)
      OP_SPECIAL: begin
        case (funct_i)
          FUNC_ADDU, FUNC_SUBU, FUNC_AND, FUNC_OR,
          FUNC_XOR, FUNC_SLT, FUNC_SLTU: writes_reg = 1'b1;
          default:                       writes_reg = 1'b0;
        endcase
      end
      OP_ADDIU, OP_ORI, OP_LUI: writes_reg = 1'b1;
      default:                  writes_reg = 1'b0;
    endcase
  end

  assign mem_access_o = is_load || is_store;

  always_comb begin
    case (opcode_i)
      OP_ADDIU, OP_ORI, OP_LUI, OP_LW, OP_SW: alu_src_imm_o = 1'b1;
      default:                                alu_src_imm_o = 1'b0;
    endcase
  end

  // R-type writes rd and the immediate forms write rt
  assign wb_sel_o = (opcode_i == OP_SPECIAL) ? RD : RT;

  // Fetch reads at the pc and MEM uses the effective address
  assign read_o         = (state_i == FETCH) || (state_i == MEM && is_load);
  assign write_o        = (state_i == MEM) && is_store;
  assign ram_addr_sel_o = state_i == MEM;

  // Nothing commits while the slave holds waitrequest
  assign fetch_done    = (state_i == FETCH) && !waitrequest_i;
  assign pc_write_en_o = fetch_done;
  assign ir_write_en_o = fetch_done;

  // Loads write straight from the bus when the read completes
  assign regfile_write_en_o = (state_i == WRITEBACK && writes_reg) ||
                              (state_i == MEM && is_load && !waitrequest_i);

  // Only loads and stores may reach MEM
  a_mem_is_access : assert final ((state_i != MEM) || mem_access_o)
    else $error("MEM state reached without a load or store");

endmodule

`default_nettype wire

// ==== source/mips_pc.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_pc
  import mips_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        write_en_i,
  input  logic        branch_taken_i,
  input  logic [31:0] target_i,
  output logic [31:0] pc_o,
  output logic        at_halt_o
);

  logic        pending_q;
  logic [31:0] pending_target_q;

  assign at_halt_o = pc_o == HALT_ADDRESS;

  // A taken branch waits here until the delay slot has been fetched
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_o      <= RESET_VECTOR;
      pending_q <= 1'b0;
    end else if (write_en_i && !at_halt_o) begin
      pc_o      <= pending_q ? pending_target_q : pc_o + 32'(WORD_BYTES);
      pending_q <= 1'b0;
    end else if (branch_taken_i) begin
      pending_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (branch_taken_i && !write_en_i) begin
      pending_target_q <= target_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/mips_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs_addr_i,
  input  logic [4:0]  rt_addr_i,
  input  logic [4:0]  wr_addr_i,
  input  logic [31:0] wr_data_i,
  input  logic        wr_en_i,
  output logic [31:0] rs_data_o,
  output logic [31:0] rt_data_o,
  output logic [31:0] v0_o
);

  logic [31:0] regs [32];

  // $zero is cleared by reset and never written after
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && wr_addr_i != 5'd0) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  assign rs_data_o = regs[rs_addr_i];
  assign rt_data_o = regs[rt_addr_i];

  // v0 is register 2
  assign v0_o = regs[2];

endmodule

`default_nettype wire

// ==== source/mips_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_alu
  import mips_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        ir_write_en_i,
  input  logic [31:0] instr_i,
  input  logic        alu_src_imm_i,
  input  logic [31:0] rs_data_i,
  input  logic [31:0] rt_data_i,
  input  logic [31:0] pc_i,
  output opcode_t     opcode_o,
  output func_t       funct_o,
  output logic [4:0]  rs_addr_o,
  output logic [4:0]  rt_addr_o,
  output logic [4:0]  rd_addr_o,
  output logic [31:0] result_o,
  output logic [31:0] effective_address_o,
  output logic        branch_taken_o,
  output logic [31:0] target_o
);

  logic [31:0] ir_q;
  logic [31:0] imm_sext;
  logic [31:0] imm_ext;
  logic [31:0] operand_b;
  logic        rs_eq_rt;

  // Cleared IR decodes as a harmless SPECIAL with no write and no branch
  always_ff @(posedge clk) begin
    if (reset) begin
      ir_q <= '0;
    end else if (ir_write_en_i) begin
      ir_q <= instr_i;
    end
  end

  assign opcode_o  = opcode_t'(ir_q[31:26]);
  assign funct_o   = func_t'(ir_q[5:0]);
  assign rs_addr_o = ir_q[25:21];
  assign rt_addr_o = ir_q[20:16];
  assign rd_addr_o = ir_q[15:11];

  assign imm_sext = {{16{ir_q[15]}}, ir_q[15:0]};

  always_comb begin
    case (opcode_o)
      OP_ORI:  imm_ext = {16'h0000, ir_q[15:0]};
      OP_LUI:  imm_ext = {ir_q[15:0], 16'h0000};
      default: imm_ext = imm_sext;
    endcase
  end

  assign operand_b = alu_src_imm_i ? imm_ext : rt_data_i;

  always_comb begin
    case (opcode_o)
      OP_SPECIAL: begin
        case (funct_o)
          FUNC_ADDU: result_o = rs_data_i + operand_b;
          FUNC_SUBU: result_o = rs_data_i - operand_b;
          FUNC_AND:  result_o = rs_data_i & operand_b;
          FUNC_OR:   result_o = rs_data_i | operand_b;
          FUNC_XOR:  result_o = rs_data_i ^ operand_b;
          FUNC_SLT:  result_o = {31'd0, $signed(rs_data_i) < $signed(operand_b)};
          FUNC_SLTU: result_o = {31'd0, rs_data_i < operand_b};
          default:   result_o = '0;
        endcase
      end
      OP_ADDIU: result_o = rs_data_i + operand_b;
      OP_ORI:   result_o = rs_data_i | operand_b;
      OP_LUI:   result_o = operand_b;
      default:  result_o = '0;
    endcase
  end

  assign effective_address_o = rs_data_i + imm_sext;

  // pc already points at the delay slot while the branch is decoded
  assign rs_eq_rt = rs_data_i == rt_data_i;

  always_comb begin
    branch_taken_o = 1'b0;
    target_o       = pc_i + {imm_sext[29:0], 2'b00};
    case (opcode_o)
      OP_BEQ: branch_taken_o = rs_eq_rt;
      OP_BNE: branch_taken_o = !rs_eq_rt;
      OP_J: begin
        branch_taken_o = 1'b1;
        target_o       = {pc_i[31:28], ir_q[25:0], 2'b00};
      end
      OP_SPECIAL: begin
        if (funct_o == FUNC_JR) begin
          branch_taken_o = 1'b1;
          target_o       = rs_data_i;
        end
      end
      default: branch_taken_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/mips_cpu_bus.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_bus
  import mips_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  output logic                  active_o,
  output logic [31:0]           register_v0_o,
  output logic [31:0]           address_o,
  output logic                  read_o,
  output logic                  write_o,
  input  logic                  waitrequest_i,
  output logic [31:0]           writedata_o,
  output logic [WORD_BYTES-1:0] byteenable_o,
  input  logic [31:0]           readdata_i
);

  // The core is big-endian, the bus is little-endian
  function automatic logic [31:0] swap_bytes(input logic [31:0] word);
    swap_bytes = {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  state_t      state;
  logic        stall;
  logic        at_halt;
  logic        mem_access;
  logic        pc_write_en;
  logic        ir_write_en;
  logic        regfile_write_en;
  wb_sel_t     wb_sel;
  logic        ctrl_read;
  logic        ram_addr_sel;
  logic        alu_src_imm;
  opcode_t     opcode;
  func_t       funct;
  logic [4:0]  rs_addr;
  logic [4:0]  rt_addr;
  logic [4:0]  rd_addr;
  logic [4:0]  wr_addr;
  logic [31:0] wr_data;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] result;
  logic [31:0] effective_address;
  logic        branch_taken;
  logic [31:0] target;
  logic [31:0] pc;
  logic [31:0] readdata_be;

  assign readdata_be = swap_bytes(readdata_i);

  // No fetch goes out once the pc reaches the halt address
  assign read_o = ctrl_read && !at_halt;
  assign stall  = (read_o || write_o) && waitrequest_i;

  mips_fsm u_fsm (
    .clk          (clk),
    .reset        (reset),
    .stall_i      (stall),
    .halt_i       (at_halt),
    .mem_access_i (mem_access),
    .state_o      (state)
  );

  mips_control u_control (
    .state_i            (state),
    .waitrequest_i      (waitrequest_i),
    .opcode_i           (opcode),
    .funct_i            (funct),
    .mem_access_o       (mem_access),
    .pc_write_en_o      (pc_write_en),
    .ir_write_en_o      (ir_write_en),
    .regfile_write_en_o (regfile_write_en),
    .wb_sel_o           (wb_sel),
    .read_o             (ctrl_read),
    .write_o            (write_o),
    .ram_addr_sel_o     (ram_addr_sel),
    .alu_src_imm_o      (alu_src_imm)
  );

  mips_pc u_pc (
    .clk            (clk),
    .reset          (reset),
    .write_en_i     (pc_write_en),
    .branch_taken_i (branch_taken),
    .target_i       (target),
    .pc_o           (pc),
    .at_halt_o      (at_halt)
  );

  always_comb begin
    case (wb_sel)
      RD:      wr_addr = rd_addr;
      RT:      wr_addr = rt_addr;
      GPR31:   wr_addr = 5'd31;
      default: wr_addr = 5'd0;
    endcase
  end

  // Loads take the word from the bus, all else the ALU result
  assign wr_data = (opcode == OP_LW) ? readdata_be : result;

  mips_regfile u_regfile (
    .clk       (clk),
    .reset     (reset),
    .rs_addr_i (rs_addr),
    .rt_addr_i (rt_addr),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .wr_en_i   (regfile_write_en),
    .rs_data_o (rs_data),
    .rt_data_o (rt_data),
    .v0_o      (register_v0_o)
  );

  mips_alu u_alu (
    .clk                 (clk),
    .reset               (reset),
    .ir_write_en_i       (ir_write_en && !at_halt),
    .instr_i             (readdata_be),
    .alu_src_imm_i       (alu_src_imm),
    .rs_data_i           (rs_data),
    .rt_data_i           (rt_data),
    .pc_i                (pc),
    .opcode_o            (opcode),
    .funct_o             (funct),
    .rs_addr_o           (rs_addr),
    .rt_addr_o           (rt_addr),
    .rd_addr_o           (rd_addr),
    .result_o            (result),
    .effective_address_o (effective_address),
    .branch_taken_o      (branch_taken),
    .target_o            (target)
  );

  assign address_o    = ram_addr_sel ? effective_address : pc;
  assign writedata_o  = swap_bytes(rt_data);
  assign byteenable_o = {WORD_BYTES{1'b1}};
  assign active_o     = state != HALT;

  // A stalled transfer must present the same address and data next cycle
  a_stall_hold : assert property (
    @(posedge clk) disable iff (reset)
    stall |=> $stable(address_o) && $stable(writedata_o)
  ) else $error("bus request changed under waitrequest");

endmodule

`default_nettype wire

// ==== verification/avalon_ram_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module avalon_ram_model
  import mips_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic [31:0]           address_i,
  input  logic                  read_i,
  input  logic                  write_i,
  input  logic [31:0]           writedata_i,
  input  logic [WORD_BYTES-1:0] byteenable_i,
  output logic [31:0]           readdata_o,
  output logic                  waitrequest_o,
  input  logic                  clear_i,
  input  logic                  load_en_i,
  input  logic [31:0]           load_addr_i,
  input  logic [31:0]           load_data_i,
  input  logic [31:0]           peek_addr_i,
  output logic [31:0]           peek_data_o
);

  logic [31:0] mem [2048];

  // Address bit 31 splits the array into boot segment and low data
  function automatic logic [10:0] word_index(input logic [31:0] addr);
    word_index = {addr[31], addr[11:2]};
  endfunction

  initial begin
    waitrequest_o = 1'b1;
    readdata_o    = '0;
  end

  assign peek_data_o = mem[word_index(peek_addr_i)];

  // Image loading only happens while the core is held in reset
  always @(posedge clk) begin
    if (clear_i) begin
      for (int i = 0; i < 2048; i++) begin
        mem[i] <= '0;
      end
    end else if (load_en_i) begin
      mem[word_index(load_addr_i)] <= load_data_i;
    end else if (write_i && !waitrequest_o) begin
      // Only enabled byte lanes are written
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (byteenable_i[b]) begin
          mem[word_index(address_i)][8*b +: 8] <= writedata_i[8*b +: 8];
        end
      end
    end
  end

  // Every transfer sees at least one wait cycle and a random number more
  always @(posedge clk) begin
    if (reset) begin
      waitrequest_o <= 1'b1;
      readdata_o    <= '0;
    end else if (!waitrequest_o) begin
      waitrequest_o <= 1'b1;
    end else if ((read_i || write_i) && ($urandom % 3) != 0) begin
      waitrequest_o <= 1'b0;
      readdata_o    <= mem[word_index(address_i)];
    end
  end

endmodule

`default_nettype wire

// ==== verification/mips_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_tb
  import mips_pkg::*;
();

  localparam int CLK_PERIOD             = 8;
  localparam int RESET_CYCLES           = 16;
  localparam int RANDOM_SEED            = 95;
  localparam int PROGRAMS               = 3;
  localparam int MAX_INSTRUCTIONS       = 400;
  localparam int CYCLES_PER_INSTRUCTION = 12;
  localparam logic [31:0] DATA_BASE     = 32'h0000_0100;

  // 100 - 7 = 93 and 100 + 7 = 107
  // (93 & 107) ^ (93 | 107) = 0x36
  // 0x12348000 + 0x36 + slt 1 + sltu 1 - sltu 0
  localparam logic [31:0] ARITH_V0    = 32'h1234_8038;
  // Stores 0xA5A51234 and 0x77 and adds them back after loading
  localparam logic [31:0] STORED_WORD = 32'hA5A5_1234;
  localparam logic [31:0] MEMORY_V0   = 32'hA5A5_12AB;
  // Six delay slots of +1 and one fall-through +10 while every +100 is skipped
  localparam logic [31:0] BRANCH_V0   = 32'd16;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  active;
  logic [31:0]           register_v0;
  logic [31:0]           address;
  logic                  read;
  logic                  write;
  logic                  waitrequest;
  logic [31:0]           writedata;
  logic [WORD_BYTES-1:0] byteenable;
  logic [31:0]           readdata;
  logic                  mem_clear;
  logic                  load_en;
  logic [31:0]           load_addr;
  logic [31:0]           load_data;
  logic [31:0]           peek_data;
  logic [31:0]           expected_v0;
  logic [31:0]           expected_word;
  logic                  check_word;
  logic [31:0]           image [$];

  always #(CLK_PERIOD / 2) clk = !clk;

  mips_cpu_bus u_dut (
    .clk           (clk),
    .reset         (reset),
    .active_o      (active),
    .register_v0_o (register_v0),
    .address_o     (address),
    .read_o        (read),
    .write_o       (write),
    .waitrequest_i (waitrequest),
    .writedata_o   (writedata),
    .byteenable_o  (byteenable),
    .readdata_i    (readdata)
  );

  avalon_ram_model u_ram (
    .clk           (clk),
    .reset         (reset),
    .address_i     (address),
    .read_i        (read),
    .write_i       (write),
    .writedata_i   (writedata),
    .byteenable_i  (byteenable),
    .readdata_o    (readdata),
    .waitrequest_o (waitrequest),
    .clear_i       (mem_clear),
    .load_en_i     (load_en),
    .load_addr_i   (load_addr),
    .load_data_i   (load_data),
    .peek_addr_i   (DATA_BASE),
    .peek_data_o   (peek_data)
  );

  function automatic logic [31:0] rtype_word(input int rs, input int rt, input int rd,
                                             input logic [5:0] funct);
    rtype_word = {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
  endfunction

  function automatic logic [31:0] itype_word(input logic [5:0] op, input int rs, input int rt,
                                             input logic [15:0] imm);
    itype_word = {op, 5'(rs), 5'(rt), imm};
  endfunction

  function automatic logic [31:0] jump_word(input logic [31:0] target);
    jump_word = {OP_J, target[27:2]};
  endfunction

  // Memory holds little-endian words while the core sees big-endian ones
  function automatic logic [31:0] byte_swapped(input logic [31:0] word);
    logic [31:0] swapped;
    for (int b = 0; b < 4; b++) begin
      swapped[8*b +: 8] = word[8*(3-b) +: 8];
    end
    byte_swapped = swapped;
  endfunction

  task automatic report_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic append_halt();
    image.push_back(rtype_word(0, 0, 0, FUNC_JR));
    image.push_back(32'h0000_0000);
  endtask

  task automatic arith_program();
    image.delete();
    image.push_back(itype_word(OP_ADDIU, 0, 8, 16'd100));
    image.push_back(itype_word(OP_ADDIU, 0, 9, 16'hFFF9));
    image.push_back(rtype_word(8, 9, 10, FUNC_ADDU));
    image.push_back(rtype_word(8, 9, 11, FUNC_SUBU));
    image.push_back(rtype_word(10, 11, 12, FUNC_AND));
    image.push_back(rtype_word(10, 11, 13, FUNC_OR));
    image.push_back(rtype_word(12, 13, 14, FUNC_XOR));
    image.push_back(rtype_word(9, 8, 15, FUNC_SLT));
    image.push_back(rtype_word(9, 8, 24, FUNC_SLTU));
    image.push_back(rtype_word(8, 9, 4, FUNC_SLTU));
    image.push_back(itype_word(OP_LUI, 0, 25, 16'h1234));
    image.push_back(itype_word(OP_ORI, 25, 25, 16'h8000));
    image.push_back(rtype_word(25, 14, 2, FUNC_ADDU));
    image.push_back(rtype_word(2, 15, 2, FUNC_ADDU));
    image.push_back(rtype_word(2, 4, 2, FUNC_ADDU));
    image.push_back(rtype_word(2, 24, 2, FUNC_SUBU));
    append_halt();
  endtask

  task automatic memory_program();
    image.delete();
    image.push_back(itype_word(OP_LUI, 0, 8, STORED_WORD[31:16]));
    image.push_back(itype_word(OP_ORI, 8, 8, STORED_WORD[15:0]));
    image.push_back(itype_word(OP_ADDIU, 0, 9, DATA_BASE[15:0]));
    image.push_back(itype_word(OP_ADDIU, 0, 10, 16'h0077));
    image.push_back(itype_word(OP_SW, 9, 8, 16'd0));
    image.push_back(itype_word(OP_SW, 9, 10, 16'd4));
    image.push_back(itype_word(OP_LW, 9, 11, 16'd0));
    image.push_back(itype_word(OP_LW, 9, 12, 16'd4));
    image.push_back(rtype_word(11, 12, 2, FUNC_ADDU));
    append_halt();
  endtask

  // Offsets count words from the delay slot
  task automatic branch_program();
    image.delete();
    image.push_back(itype_word(OP_ADDIU, 0, 8, 16'd5));
    image.push_back(itype_word(OP_ADDIU, 0, 9, 16'd5));
    image.push_back(itype_word(OP_ADDIU, 0, 2, 16'd0));
    image.push_back(itype_word(OP_BEQ, 8, 9, 16'd2));
    image.push_back(itype_word(OP_ADDIU, 2, 2, 16'd1));
    image.push_back(itype_word(OP_ADDIU, 2, 2, 16'd100));
    image.push_back(itype_word(OP_BNE, 8, 9, 16'd2));
    image.push_back(itype_word(OP_ADDIU, 2, 2, 16'd1));
    image.push_back(itype_word(OP_ADDIU, 2, 2, 16'd10));
    image.push_back(itype_word(OP_BNE, 8, 0, 16'd2));
    image.push_back(itype_word(OP_ADDIU, 2, 2, 16'd1));
    image.push_back(itype_word(OP_ADDIU, 2, 2, 16'd100));
    image.push_back(itype_word(OP_BEQ, 8, 0, 16'd2));
    image.push_back(itype_word(OP_ADDIU, 2, 2, 16'd1));
    image.push_back(jump_word(RESET_VECTOR + 32'd68));
    image.push_back(itype_word(OP_ADDIU, 2, 2, 16'd1));
    image.push_back(itype_word(OP_ADDIU, 2, 2, 16'd100));
    image.push_back(rtype_word(0, 0, 0, FUNC_JR));
    image.push_back(itype_word(OP_ADDIU, 2, 2, 16'd1));
  endtask

  task automatic load_and_run(input logic [31:0] v0, input logic mem_check,
                              input logic [31:0] word);
    @(posedge clk);
    reset         <= 1'b1;
    mem_clear     <= 1'b1;
    expected_v0   <= v0;
    check_word    <= mem_check;
    expected_word <= word;
    @(posedge clk);
    mem_clear <= 1'b0;
    foreach (image[i]) begin
      load_en   <= 1'b1;
      load_addr <= RESET_VECTOR + 32'(i * 4);
      load_data <= byte_swapped(image[i]);
      @(posedge clk);
    end
    load_en <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    while (active) begin
      @(posedge clk);
    end
    // A few idle cycles so the halt checks see the core parked
    repeat (4) @(posedge clk);
  endtask

  a_first_fetch : assert property (@(posedge clk)
    $fell(reset) |-> active && !read && !write
    ##1 read && !write && address == RESET_VECTOR)
    else report_error("first bus access is not a read at the reset vector");

  a_request_held : assert property (@(posedge clk) disable iff (reset)
    (read || write) && waitrequest |=>
    $stable(address) && $stable(read) && $stable(write) && $stable(writedata))
    else report_error("bus request changed while waitrequest was high");

  a_full_word : assert property (@(posedge clk) byteenable == {WORD_BYTES{1'b1}})
    else report_error("byteenable is not all ones");

  a_final_v0 : assert property (@(posedge clk) disable iff (reset)
    $fell(active) |-> register_v0 == expected_v0)
    else report_error($sformatf("v0 is %h, expected %h", register_v0, expected_v0));

  a_stored_word : assert property (@(posedge clk) disable iff (reset)
    $fell(active) && check_word |-> peek_data == expected_word)
    else report_error($sformatf("stored word is %h, expected %h", peek_data, expected_word));

  // Halted core stays parked until the next reset
  a_halt_quiet : assert property (@(posedge clk) disable iff (reset)
    !active |-> !read && !write ##1 !active && !read && !write && $stable(register_v0))
    else report_error("bus activity or v0 change after halt");

  initial begin
    #(PROGRAMS * MAX_INSTRUCTIONS * CYCLES_PER_INSTRUCTION * CLK_PERIOD);
    $display("Timeout: the core never halted within the instruction budget");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(RANDOM_SEED));
    reset         = 1'b1;
    mem_clear     = 1'b0;
    load_en       = 1'b0;
    load_addr     = '0;
    load_data     = '0;
    expected_v0   = '0;
    expected_word = '0;
    check_word    = 1'b0;
    arith_program();
    load_and_run(ARITH_V0, 1'b0, '0);
    memory_program();
    load_and_run(MEMORY_V0, 1'b1, byte_swapped(STORED_WORD));
    branch_program();
    load_and_run(BRANCH_V0, 1'b0, '0);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/mips_pkg.sv
source/mips_fsm.sv
source/mips_control.sv
source/mips_pc.sv
source/mips_regfile.sv
source/mips_alu.sv
source/mips_cpu_bus.sv
verification/avalon_ram_model.sv
verification/mips_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mips_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= ** PASS **
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(wildcard source/*.sv) $(wildcard verification/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qFx "$(PASS_TEXT)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
